//--- logic/mgt_regs_pkg.sv
/*
  Shared register bus definitions for the transceiver channel wrapper.
  Holds the host address and data types, the command and response
  structs broadcast to and collected from the lane register blocks,
  the size of one lane's address block and the lane register offsets.
  Imported by the RTL and by the testbench model.
*/

package mgt_regs_pkg;

  // ------------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------------

  // In-block offset bits, one lane owns 16 KiB of byte addresses
  localparam int REG_OFS_W = 14;

  // Host address spans up to four lane blocks
  localparam int REG_AWIDTH = REG_OFS_W + 2;

  localparam int REG_DWIDTH = 32;

  // Address span of one lane block in bytes
  localparam int unsigned REG_BLOCK_SIZE = 1 << REG_OFS_W;

  typedef logic [REG_AWIDTH-1:0] reg_addr_t;
  typedef logic [REG_OFS_W-1:0]  reg_ofs_t;
  typedef logic [REG_DWIDTH-1:0] reg_data_t;

  // Device id and discovery port number as reported in PORT_INFO
  typedef logic [15:0] dev_id_t;
  typedef logic [7:0]  port_num_t;

  // ------------------------------------------------------------------------
  // Bus structs
  // ------------------------------------------------------------------------

  // Command seen by every lane, strobes are single cycle
  typedef struct packed {
    logic      wr_req;
    logic      rd_req;
    reg_addr_t addr;
    reg_data_t data;
  } reg_cmd_t;

  // One lane's read response
  typedef struct packed {
    logic      rd_resp;
    reg_data_t rd_data;
  } reg_resp_t;

  // ------------------------------------------------------------------------
  // Lane register map, byte offsets inside a lane block
  // ------------------------------------------------------------------------

  // Read only, device id in 31:16 and port number in 7:0
  localparam reg_ofs_t OFS_PORT_INFO   = reg_ofs_t'('h0);
  // Bit 0 is tx_disable
  localparam reg_ofs_t OFS_CONTROL     = reg_ofs_t'('h4);
  // Bit 0 link_up, bit 1 synchronized link_ok
  localparam reg_ofs_t OFS_STATUS      = reg_ofs_t'('h8);
  // Frames seen while link is up, any write clears it
  localparam reg_ofs_t OFS_FRAME_COUNT = reg_ofs_t'('hC);

endpackage

//--- logic/regport_cmd_stage.sv
/*
  Host side command stage of the register bus.
  Samples the host read and write strobes with address and data, and
  broadcasts requests that fall inside the subsystem window to all
  lanes one cycle later. A request outside the window is dropped and
  flagged by a one cycle bad_addr_o pulse.
*/

`timescale 1ns/1ps

module regport_cmd_stage #(
  parameter int unsigned LANES    = 2,
  parameter int unsigned REG_BASE = 0
) (
  input  logic                    bus_clk_i,
  input  logic                    reset_i,
  input  logic                    host_wr_req_i,
  input  logic                    host_rd_req_i,
  input  mgt_regs_pkg::reg_addr_t host_addr_i,
  input  mgt_regs_pkg::reg_data_t host_wr_data_i,
  output mgt_regs_pkg::reg_cmd_t  cmd_o,
  output logic                    bad_addr_o
);

  import mgt_regs_pkg::*;

  // First byte past the last lane block
  localparam int unsigned WIN_END = REG_BASE + LANES * REG_BLOCK_SIZE;

  logic      in_window;
  logic      wr_q;
  logic      rd_q;
  logic      bad_q;
  reg_addr_t addr_q;
  reg_data_t data_q;

  if (LANES < 1 || LANES > 4) begin : g_lanes_check
    $error("LANES must be between 1 and 4");
  end

  assign in_window = (32'(host_addr_i) >= REG_BASE) && (32'(host_addr_i) < WIN_END);

  // Strobes, only in-window requests go out
  always_ff @(posedge bus_clk_i) begin
    if (reset_i) begin
      wr_q  <= 1'b0;
      rd_q  <= 1'b0;
      bad_q <= 1'b0;
    end else begin
      wr_q  <= host_wr_req_i & in_window;
      rd_q  <= host_rd_req_i & in_window;
      bad_q <= (host_wr_req_i | host_rd_req_i) & ~in_window;
    end
  end

  // Payload follows every cycle
  always_ff @(posedge bus_clk_i) begin
    addr_q <= host_addr_i;
    data_q <= host_wr_data_i;
  end

  assign cmd_o = '{wr_req: wr_q, rd_req: rd_q, addr: addr_q, data: data_q};
  assign bad_addr_o = bad_q;

  // Host never issues a read and a write in the same cycle
  a_strobes_exclusive : assert property (
    @(posedge bus_clk_i) disable iff (reset_i)
    !(host_wr_req_i && host_rd_req_i)
  );

endmodule

//--- logic/mgt_lane_regs.sv
/*
  Register block of one transceiver lane.
  Decodes broadcast commands that fall inside this lane's 16 KiB block
  and holds the port info, control, status and frame count registers.
  The link state is synchronized into the bus clock domain, and the
  transmit disable bit from the control word gates link_up_o.
  Read data is returned one cycle after the command.
*/

`timescale 1ns/1ps

module mgt_lane_regs #(
  parameter int unsigned LANE_BASE = 0,
  parameter int unsigned PORTNUM   = 0
) (
  input  logic                    bus_clk_i,
  input  logic                    reset_i,
  input  mgt_regs_pkg::reg_cmd_t  cmd_i,
  input  mgt_regs_pkg::dev_id_t   device_id_i,
  input  logic                    link_ok_i,
  input  logic                    frame_strobe_i,
  output mgt_regs_pkg::reg_resp_t resp_o,
  output logic                    link_up_o,
  output logic                    tx_disable_o
);

  import mgt_regs_pkg::*;

  localparam port_num_t PORT_NUM = port_num_t'(PORTNUM);

  logic      in_block;
  reg_ofs_t  ofs;
  logic      wr_hit;
  logic      rd_hit;

  logic      tx_disable_q;
  logic      link_meta_q;
  logic      link_sync_q;
  reg_data_t frame_cnt_q;

  reg_data_t rd_mux;
  logic      rd_resp_q;
  reg_data_t rd_data_q;

  // ------------------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------------------

  assign in_block = (32'(cmd_i.addr) >= LANE_BASE) &&
                    (32'(cmd_i.addr) < LANE_BASE + REG_BLOCK_SIZE);

  // Offset relative to the start of this lane's block
  assign ofs    = reg_ofs_t'(32'(cmd_i.addr) - LANE_BASE);
  assign wr_hit = cmd_i.wr_req & in_block;
  assign rd_hit = cmd_i.rd_req & in_block;

  // ------------------------------------------------------------------------
  // Control and link status
  // ------------------------------------------------------------------------

  always_ff @(posedge bus_clk_i) begin
    if (reset_i) begin
      tx_disable_q <= 1'b0;
    end else if (wr_hit && ofs == OFS_CONTROL) begin
      tx_disable_q <= cmd_i.data[0];
    end
  end

  // Two flop synchronizer for the transceiver link state
  always_ff @(posedge bus_clk_i) begin
    if (reset_i) begin
      link_meta_q <= 1'b0;
      link_sync_q <= 1'b0;
    end else begin
      link_meta_q <= link_ok_i;
      link_sync_q <= link_meta_q;
    end
  end

  // A disabled transmitter never reports the link as up
  assign link_up_o    = link_sync_q & ~tx_disable_q;
  assign tx_disable_o = tx_disable_q;

  // ------------------------------------------------------------------------
  // Frame counter
  // ------------------------------------------------------------------------

  // Clear on write wins over a coincident frame strobe
  always_ff @(posedge bus_clk_i) begin
    if (reset_i) begin
      frame_cnt_q <= '0;
    end else if (wr_hit && ofs == OFS_FRAME_COUNT) begin
      frame_cnt_q <= '0;
    end else if (frame_strobe_i && link_up_o) begin
      frame_cnt_q <= frame_cnt_q + 1'b1;
    end
  end

  // ------------------------------------------------------------------------
  // Read path
  // ------------------------------------------------------------------------

  always_comb begin
    rd_mux = '0;
    case (ofs)
      OFS_PORT_INFO:   rd_mux = {device_id_i, 8'h00, PORT_NUM};
      OFS_CONTROL:     rd_mux = {31'b0, tx_disable_q};
      OFS_STATUS:      rd_mux = {30'b0, link_sync_q, link_up_o};
      OFS_FRAME_COUNT: rd_mux = frame_cnt_q;
      default:         rd_mux = '0;
    endcase
  end

  always_ff @(posedge bus_clk_i) begin
    if (reset_i) begin
      rd_resp_q <= 1'b0;
    end else begin
      rd_resp_q <= rd_hit;
    end
  end

  always_ff @(posedge bus_clk_i) begin
    rd_data_q <= rd_mux;
  end

  assign resp_o = '{rd_resp: rd_resp_q, rd_data: rd_data_q};

  // Response only for a read that landed in this lane's block
  a_resp_after_read : assert property (
    @(posedge bus_clk_i) disable iff (reset_i)
    resp_o.rd_resp |-> $past(cmd_i.rd_req && ((32'(cmd_i.addr) - LANE_BASE) < REG_BLOCK_SIZE))
  );

endmodule

//--- logic/regport_resp_mux.sv
/*
  Read response collector of the register bus.
  Picks the data of the lane that answers a read, or zero when no lane
  answers, and registers it together with the response strobe toward
  the host. Lane blocks do not overlap, so one answer per cycle at most.
*/

`timescale 1ns/1ps

module regport_resp_mux #(
  parameter int unsigned LANES = 2
) (
  input  logic                    bus_clk_i,
  input  logic                    reset_i,
  input  mgt_regs_pkg::reg_resp_t lane_resp_i [LANES],
  output logic                    rd_resp_o,
  output mgt_regs_pkg::reg_data_t rd_data_o
);

  import mgt_regs_pkg::*;

  logic [LANES-1:0] resp_vec;
  reg_data_t        data_sel;
  logic             rd_resp_q;
  reg_data_t        rd_data_q;

  // OR of the answering lanes, silent lanes contribute zero
  always_comb begin
    resp_vec = '0;
    data_sel = '0;
    for (int l = 0; l < LANES; l++) begin
      resp_vec[l] = lane_resp_i[l].rd_resp;
      if (lane_resp_i[l].rd_resp) begin
        data_sel = data_sel | lane_resp_i[l].rd_data;
      end
    end
  end

  always_ff @(posedge bus_clk_i) begin
    if (reset_i) begin
      rd_resp_q <= 1'b0;
    end else begin
      rd_resp_q <= |resp_vec;
    end
  end

  always_ff @(posedge bus_clk_i) begin
    rd_data_q <= data_sel;
  end

  assign rd_resp_o = rd_resp_q;
  assign rd_data_o = rd_data_q;

  // Lane address decode must never let two lanes answer together
  a_one_lane_answers : assert property (
    @(posedge bus_clk_i) disable iff (reset_i)
    $onehot0(resp_vec)
  );

endmodule

//--- logic/mgt_channel_array.sv
/*
  Register and status side of a multi-lane transceiver channel wrapper.
  Host register strobes pass the command stage, are broadcast to one
  register block per lane and the answering lane's read data returns
  through the response mux. Reads complete exactly 3 cycles after the
  request. Lane l sits at REG_BASE + l * 16 KiB with port number
  PORTNUM_BASE + l.
*/

`timescale 1ns/1ps

module mgt_channel_array #(
  parameter int unsigned LANES        = 2,
  parameter int unsigned REG_BASE     = 0,
  parameter int unsigned PORTNUM_BASE = 4
) (
  input  logic                    bus_clk_i,
  input  logic                    reset_i,

  // Host register port
  input  logic                    host_wr_req_i,
  input  logic                    host_rd_req_i,
  input  mgt_regs_pkg::reg_addr_t host_addr_i,
  input  mgt_regs_pkg::reg_data_t host_wr_data_i,
  output logic                    host_rd_resp_o,
  output mgt_regs_pkg::reg_data_t host_rd_data_o,
  output logic                    bad_addr_o,

  // Discovery
  input  mgt_regs_pkg::dev_id_t   device_id_i,

  // Per-lane status and control
  input  logic [LANES-1:0]        link_ok_i,
  input  logic [LANES-1:0]        frame_strobe_i,
  output logic [LANES-1:0]        link_up_o,
  output logic [LANES-1:0]        tx_disable_o
);

  import mgt_regs_pkg::*;

  reg_cmd_t  bus_cmd;
  reg_resp_t lane_resp [LANES];

  // ------------------------------------------------------------------------
  // Command stage
  // ------------------------------------------------------------------------

  regport_cmd_stage #(
    .LANES    (LANES),
    .REG_BASE (REG_BASE)
  ) u_cmd_stage (
    .bus_clk_i      (bus_clk_i),
    .reset_i        (reset_i),
    .host_wr_req_i  (host_wr_req_i),
    .host_rd_req_i  (host_rd_req_i),
    .host_addr_i    (host_addr_i),
    .host_wr_data_i (host_wr_data_i),
    .cmd_o          (bus_cmd),
    .bad_addr_o     (bad_addr_o)
  );

  // ------------------------------------------------------------------------
  // Lanes
  // ------------------------------------------------------------------------

  for (genvar l = 0; l < LANES; l++) begin : g_lane
    mgt_lane_regs #(
      .LANE_BASE (REG_BASE + l * REG_BLOCK_SIZE),
      .PORTNUM   (PORTNUM_BASE + l)
    ) u_lane_regs (
      .bus_clk_i      (bus_clk_i),
      .reset_i        (reset_i),
      .cmd_i          (bus_cmd),
      .device_id_i    (device_id_i),
      .link_ok_i      (link_ok_i[l]),
      .frame_strobe_i (frame_strobe_i[l]),
      .resp_o         (lane_resp[l]),
      .link_up_o      (link_up_o[l]),
      .tx_disable_o   (tx_disable_o[l])
    );
  end

  // ------------------------------------------------------------------------
  // Read response
  // ------------------------------------------------------------------------

  regport_resp_mux #(
    .LANES (LANES)
  ) u_resp_mux (
    .bus_clk_i   (bus_clk_i),
    .reset_i     (reset_i),
    .lane_resp_i (lane_resp),
    .rd_resp_o   (host_rd_resp_o),
    .rd_data_o   (host_rd_data_o)
  );

endmodule

//--- verification/mgt_channel_model.svh
/*
  Reference model of the lane registers, included inside the testbench
  module body. Tracks control, link and frame count state per lane,
  the expected host read data with the cycle each answer is due, and
  the cycles in which a bad address pulse is due.
*/

`ifndef MGT_CHANNEL_MODEL_SVH
`define MGT_CHANNEL_MODEL_SVH

logic      m_tx_dis  [TB_LANES];
logic      m_link_ok [TB_LANES];
reg_data_t m_frames  [TB_LANES];

// Expected read data and the cycle in which it reaches the host
reg_data_t exp_data_q [$];
int        exp_due_q  [$];
int        bad_due_q  [$];

function automatic void model_reset();
  for (int l = 0; l < TB_LANES; l++) begin
    m_tx_dis[l]  = 1'b0;
    m_link_ok[l] = 1'b0;
    m_frames[l]  = '0;
  end
  exp_data_q.delete();
  exp_due_q.delete();
  bad_due_q.delete();
endfunction

function automatic int lane_addr(input int lane, input int ofs);
  return TB_REG_BASE + lane * REG_BLOCK_SIZE + ofs;
endfunction

function automatic logic model_in_window(input int addr);
  return (addr >= TB_REG_BASE) && (addr < TB_REG_BASE + TB_LANES * REG_BLOCK_SIZE);
endfunction

// Link only counts as up while the transmitter is enabled
function automatic logic model_link_up(input int lane);
  return m_link_ok[lane] & ~m_tx_dis[lane];
endfunction

function automatic lane_vec_t model_tx_vec();
  lane_vec_t v;
  for (int l = 0; l < TB_LANES; l++) begin
    v[l] = m_tx_dis[l];
  end
  return v;
endfunction

function automatic lane_vec_t model_link_vec();
  lane_vec_t v;
  for (int l = 0; l < TB_LANES; l++) begin
    v[l] = model_link_up(l);
  end
  return v;
endfunction

function automatic void model_set_link(input lane_vec_t v);
  for (int l = 0; l < TB_LANES; l++) begin
    m_link_ok[l] = v[l];
  end
endfunction

function automatic void model_frame(input int lane);
  if (model_link_up(lane)) begin
    m_frames[lane] = m_frames[lane] + 32'd1;
  end
endfunction

function automatic void model_write(input int addr, input reg_data_t data);
  int lane;
  int ofs;
  lane = (addr - TB_REG_BASE) / REG_BLOCK_SIZE;
  ofs  = (addr - TB_REG_BASE) % REG_BLOCK_SIZE;
  if (ofs == 'h4) begin
    m_tx_dis[lane] = data[0];
  end else if (ofs == 'hC) begin
    m_frames[lane] = '0;
  end
endfunction

function automatic reg_data_t model_read(input int addr, input dev_id_t dev);
  int lane;
  int ofs;
  lane = (addr - TB_REG_BASE) / REG_BLOCK_SIZE;
  ofs  = (addr - TB_REG_BASE) % REG_BLOCK_SIZE;
  case (ofs)
    'h0:     return {dev, 8'h00, 8'(TB_PORTNUM_BASE + lane)};
    'h4:     return {31'b0, m_tx_dis[lane]};
    'h8:     return {30'b0, m_link_ok[lane], model_link_up(lane)};
    'hC:     return m_frames[lane];
    default: return '0;
  endcase
endfunction

`endif

//--- verification/mgt_channel_array_tb.sv
/*
  Testbench of the transceiver channel register array.
  Drives random host register traffic, link phases and frame strobes
  on the falling clock edge and checks every read response, bad address
  pulse and lane output against the included reference model.
*/

`timescale 1ns/1ps

module mgt_channel_array_tb;

  import mgt_regs_pkg::*;

  localparam int TB_LANES        = 2;
  localparam int TB_REG_BASE     = 0;
  localparam int TB_PORTNUM_BASE = 4;
  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 8;

  // Operation counts per test, the watchdog is sized from them
  localparam int CTRL_WRITES  = 12;
  localparam int LINK_PHASES  = 6;
  localparam int BAD_OPS      = 12;
  localparam int STREAM_READS = 24;
  localparam int N_OPS = 12 + 2 * CTRL_WRITES + 6 * LINK_PHASES + BAD_OPS + STREAM_READS;
  localparam int TIMEOUT_NS = N_OPS * 10 * CLK_PERIOD + 4 * RESET_CYCLES * CLK_PERIOD;

  typedef logic [TB_LANES-1:0] lane_vec_t;

  logic      bus_clk = 1'b0;
  logic      reset;
  logic      host_wr_req;
  logic      host_rd_req;
  reg_addr_t host_addr;
  reg_data_t host_wr_data;
  logic      host_rd_resp;
  reg_data_t host_rd_data;
  logic      bad_addr;
  dev_id_t   device_id;
  lane_vec_t link_ok;
  lane_vec_t frame_strobe;
  lane_vec_t link_up;
  lane_vec_t tx_disable;

  int cyc = 0;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  `include "mgt_channel_model.svh"

  mgt_channel_array #(
    .LANES        (TB_LANES),
    .REG_BASE     (TB_REG_BASE),
    .PORTNUM_BASE (TB_PORTNUM_BASE)
  ) u_mgt_channel_array (
    .bus_clk_i      (bus_clk),
    .reset_i        (reset),
    .host_wr_req_i  (host_wr_req),
    .host_rd_req_i  (host_rd_req),
    .host_addr_i    (host_addr),
    .host_wr_data_i (host_wr_data),
    .host_rd_resp_o (host_rd_resp),
    .host_rd_data_o (host_rd_data),
    .bad_addr_o     (bad_addr),
    .device_id_i    (device_id),
    .link_ok_i      (link_ok),
    .frame_strobe_i (frame_strobe),
    .link_up_o      (link_up),
    .tx_disable_o   (tx_disable)
  );

  always #(CLK_PERIOD / 2) bus_clk = ~bus_clk;

  always @(posedge bus_clk) begin
    cyc <= cyc + 1;
  end

  function automatic void log_error(input string msg);
    $display("%s", msg);
    errors++;
  endfunction

  // --------------------------------------------------------------------------
  // Response monitor, answers and bad address pulses must land when due
  // --------------------------------------------------------------------------

  always @(negedge bus_clk) begin
    logic      resp_due;
    logic      bad_due;
    reg_data_t exp_data;
    if (!reset) begin
      resp_due = (exp_due_q.size() > 0) && (exp_due_q[0] == cyc);
      exp_data = '0;
      if (resp_due) begin
        exp_data = exp_data_q.pop_front();
        void'(exp_due_q.pop_front());
      end
      assert (host_rd_resp == resp_due)
        else log_error($sformatf("** Error: host_rd_resp_o = 0x%0h, expected 0x%0h (cycle %0d)",
                                 host_rd_resp, resp_due, cyc));
      if (resp_due && host_rd_resp) begin
        assert (host_rd_data == exp_data)
          else log_error($sformatf("** Error: host_rd_data_o = 0x%08h, expected 0x%08h",
                                   host_rd_data, exp_data));
      end
      bad_due = (bad_due_q.size() > 0) && (bad_due_q[0] == cyc);
      if (bad_due) begin
        void'(bad_due_q.pop_front());
      end
      assert (bad_addr == bad_due)
        else log_error($sformatf("** Error: bad_addr_o = 0x%0h, expected 0x%0h (cycle %0d)",
                                 bad_addr, bad_due, cyc));
    end
  end

  // One request per call, entered and left on a falling edge
  task automatic drive_op(input logic is_wr, input int addr, input reg_data_t data);
    host_wr_req  = is_wr;
    host_rd_req  = ~is_wr;
    host_addr    = reg_addr_t'(addr);
    host_wr_data = data;
    if (!model_in_window(addr)) begin
      bad_due_q.push_back(cyc + 1);
    end else if (is_wr) begin
      model_write(addr, data);
    end else begin
      exp_data_q.push_back(model_read(addr, device_id));
      exp_due_q.push_back(cyc + 3);
    end
    @(negedge bus_clk);
    host_wr_req = 1'b0;
    host_rd_req = 1'b0;
  endtask

  // Queues are looked at on the rising edge, the monitor pops them on the falling one
  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((exp_due_q.size() > 0 || bad_due_q.size() > 0) && waited < 10) begin
      @(posedge bus_clk);
      waited++;
    end
    assert (exp_due_q.size() == 0 && bad_due_q.size() == 0)
      else log_error("Expected bus responses did not arrive within 10 cycles");
    @(negedge bus_clk);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %-14s passed", name);
    end else begin
      tests_failed++;
      $display("test %-14s failed with %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic read_lane_state();
    for (int l = 0; l < TB_LANES; l++) begin
      drive_op(1'b0, lane_addr(l, 'h4), '0);
      drive_op(1'b0, lane_addr(l, 'h8), '0);
      drive_op(1'b0, lane_addr(l, 'hC), '0);
    end
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial begin
    int        errs;
    int        lane;
    reg_data_t data;
    lane_vec_t tx_before;
    void'($urandom(2));
    reset        = 1'b1;
    host_wr_req  = 1'b0;
    host_rd_req  = 1'b0;
    host_addr    = '0;
    host_wr_data = '0;
    device_id    = dev_id_t'($urandom);
    link_ok      = '0;
    frame_strobe = '0;
    model_reset();
    repeat (RESET_CYCLES) @(posedge bus_clk);
    @(negedge bus_clk);
    reset = 1'b0;

    errs = errors;
    assert ({link_up, tx_disable, host_rd_resp, bad_addr} == '0)
      else log_error($sformatf(
        "** Error: {link_up_o, tx_disable_o, host_rd_resp_o, bad_addr_o} = 0x%0h, expected 0x0",
        {link_up, tx_disable, host_rd_resp, bad_addr}));
    for (int l = 0; l < TB_LANES; l++) begin
      drive_op(1'b0, lane_addr(l, 'h4), '0);
      drive_op(1'b0, lane_addr(l, 'hC), '0);
    end
    wait_drain();
    finish_test("reset", errs);

    errs = errors;
    for (int l = 0; l < TB_LANES; l++) begin
      drive_op(1'b0, lane_addr(l, 'h0), '0);
    end
    wait_drain();
    finish_test("port_info", errs);

    // Control writes with every link up, tx_disable must mask link_up
    errs = errors;
    link_ok = '1;
    model_set_link(link_ok);
    repeat (5) @(negedge bus_clk);
    for (int i = 0; i < CTRL_WRITES; i++) begin
      lane      = $urandom_range(TB_LANES - 1);
      data      = $urandom;
      tx_before = model_tx_vec();
      drive_op(1'b1, lane_addr(lane, 'h4), data);
      assert (tx_disable == tx_before)
        else log_error($sformatf("** Error: tx_disable_o = 0x%0h, expected 0x%0h",
                                 tx_disable, tx_before));
      @(negedge bus_clk);
      assert (tx_disable == model_tx_vec())
        else log_error($sformatf("** Error: tx_disable_o = 0x%0h, expected 0x%0h",
                                 tx_disable, model_tx_vec()));
      assert (link_up == model_link_vec())
        else log_error($sformatf("** Error: link_up_o = 0x%0h, expected 0x%0h",
                                 link_up, model_link_vec()));
      drive_op(1'b0, lane_addr(lane, 'h4), '0);
    end
    wait_drain();
    finish_test("control", errs);

    errs = errors;
    for (int p = 0; p < LINK_PHASES; p++) begin
      link_ok = lane_vec_t'($urandom);
      model_set_link(link_ok);
      repeat (5) @(negedge bus_clk);
      repeat (8) begin
        frame_strobe = lane_vec_t'($urandom);
        for (int l = 0; l < TB_LANES; l++) begin
          if (frame_strobe[l]) begin
            model_frame(l);
          end
        end
        @(negedge bus_clk);
      end
      frame_strobe = '0;
      read_lane_state();
      if ($urandom_range(1) == 1) begin
        drive_op(1'b1, lane_addr($urandom_range(TB_LANES - 1), 'hC), $urandom);
      end
    end
    wait_drain();
    finish_test("link_frames", errs);

    // Out of window traffic must leave every lane untouched
    errs = errors;
    drive_op(1'b1, 3 * REG_BLOCK_SIZE + 'h4, '1);
    for (int i = 0; i < BAD_OPS; i++) begin
      drive_op(logic'($urandom_range(1)),
               $urandom_range(2 ** $bits(reg_addr_t) - 1,
                              TB_REG_BASE + TB_LANES * REG_BLOCK_SIZE),
               $urandom);
    end
    read_lane_state();
    wait_drain();
    finish_test("bad_addr", errs);

    errs = errors;
    for (int i = 0; i < STREAM_READS; i++) begin
      drive_op(1'b0, lane_addr($urandom_range(TB_LANES - 1), 4 * $urandom_range(4)), '0);
    end
    wait_drain();
    finish_test("back_to_back", errs);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- mgt_channel_array.f
+incdir+verification
logic/mgt_regs_pkg.sv
logic/regport_cmd_stage.sv
logic/mgt_lane_regs.sv
logic/regport_resp_mux.sv
logic/mgt_channel_array.sv
verification/mgt_channel_array_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the channel array testbench with Verilator.
# Exit status is zero only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module mgt_channel_array_tb \
  -f mgt_channel_array.f &&
./obj_dir/Vmgt_channel_array_tb | tee /dev/stderr | grep -qx "PASS: all tests" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
